// ==== Makefile ====
# Verilator build and run of the floppy controller testbench

VERILATOR ?= verilator
TOP       ?= fdc_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
SIMFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP) $(SIMFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/fdc_axil_slave.sv ====
// ======================================================================
// AXI4-Lite slave producing single cycle register strobes
// ======================================================================
`timescale 1ns/1ns

module fdc_axil_slave (
   input  logic                                 clk,
   input  logic                                 motor_start,
   input  logic                                 awvalid,
   input  logic [fdc_reg_pkg::AXI_ADDR_W-1:0]   awaddr,
   output logic                                 awready,
   input  logic                                 wvalid,
   input  logic [fdc_reg_pkg::AXI_DATA_W-1:0]   wdata,
   input  logic [fdc_reg_pkg::AXI_DATA_W/8-1:0] wstrb,
   output logic                                 wready,
   output logic                                 bvalid,
   output logic [1:0]                           bresp,
   input  logic                                 bready,
   input  logic                                 arvalid,
   input  logic [fdc_reg_pkg::AXI_ADDR_W-1:0]   araddr,
   output logic                                 arready,
   output logic                                 rvalid,
   output logic [fdc_reg_pkg::AXI_DATA_W-1:0]   rdata,
   output logic [1:0]                           rresp,
   input  logic                                 rready,
   fdc_bus_if.slave                             bus
);

   logic                   bus_free;     // no response outstanding
   logic                   wr_ok;        // write handshake this cycle
   logic                   rd_ok;        // read handshake this cycle
   logic                   wr_pend;
   logic                   rd_pend;
   fdc_reg_pkg::reg_addr_e addr_q;
   logic [7:0]             wdata_q;
   logic [7:0]             rdata_q;

   assign bus_free = !bvalid && !rvalid && !rd_pend;
   assign wr_ok    = awvalid && wvalid && bus_free;
   assign rd_ok    = arvalid && bus_free && !wr_ok;  // write wins a tie

   assign awready = wr_ok;   // aw and w always together
   assign wready  = wr_ok;
   assign arready = rd_ok;
   assign bresp   = 2'b00;   // always OKAY
   assign rresp   = 2'b00;
   assign rdata   = {{(fdc_reg_pkg::AXI_DATA_W-8){1'b0}}, rdata_q};

   assign bus.wr_stb = wr_pend;
   assign bus.rd_stb = rd_pend;
   assign bus.addr   = addr_q;
   assign bus.wdata  = wdata_q;

   // handshake and response state
   always_ff @(posedge clk or posedge motor_start) begin
      if (motor_start) begin
         wr_pend <= 1'b0;
         rd_pend <= 1'b0;
         bvalid  <= 1'b0;
         rvalid  <= 1'b0;
      end else begin
         wr_pend <= wr_ok && wstrb[0];   // byte 0 masked, response only
         rd_pend <= rd_ok;
         if (wr_ok)
            bvalid <= 1'b1;              // same cycle as wr_stb
         else if (bready)
            bvalid <= 1'b0;
         if (rd_pend)
            rvalid <= 1'b1;              // rises with the captured byte
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   // address, write byte and read byte
   always_ff @(posedge clk) begin
      if (wr_ok) begin
         addr_q  <= fdc_reg_pkg::reg_addr_e'(awaddr[3:2]);
         wdata_q <= wdata[7:0];
      end else if (rd_ok) begin
         addr_q  <= fdc_reg_pkg::reg_addr_e'(araddr[3:2]);
      end
      if (rd_pend)
         rdata_q <= bus.rdata;
   end

endmodule

// ==== hw/fdc_bus_if.sv ====
// ======================================================================
// decoded register access from the AXI4-Lite slave to the engine
// ======================================================================
`timescale 1ns/1ns

interface fdc_bus_if;

   logic                   wr_stb;       // one cycle per accepted write
   logic                   rd_stb;       // one cycle, rdata sampled here
   fdc_reg_pkg::reg_addr_e addr;
   logic [7:0]             wdata;
   logic [7:0]             rdata;        // combinational from addr

   modport slave (
      output wr_stb, rd_stb, addr, wdata,
      input  rdata
   );

   modport engine (
      input  wr_stb, rd_stb, addr, wdata,
      output rdata
   );

endinterface

// ==== hw/fdc_cmd_engine.sv ====
// ======================================================================
// controller registers, command decode, busy FSM and irq
// ======================================================================
`timescale 1ns/1ns

module fdc_cmd_engine #(
   parameter logic [31:0] RESTORE_DELAY = fdc_drive_pkg::DEF_RESTORE_DELAY,
   parameter logic [31:0] SEEK_DELAY    = fdc_drive_pkg::DEF_SEEK_DELAY,
   parameter logic [31:0] STEP_DELAY    = fdc_drive_pkg::DEF_STEP_DELAY
) (
   input  logic       clk,
   input  logic       motor_start,
   input  logic       wr_prot,
   input  logic [1:0] drv_sel,
   input  logic       drv_side,
   input  logic       motor_on,
   input  logic       spun_up,
   input  logic       index_pulse,
   output logic       motor_kick,   // retrigger the motor counter
   output logic       irq,
   fdc_bus_if.engine  bus,
   fdc_io_if.engine   io
);

   fdc_drive_pkg::fdc_state_e state;
   fdc_reg_pkg::cmd_op_e      op;       // opcode of the byte being written
   logic [7:0]                cmd;      // write only from the cpu side
   logic [7:0]                track;
   logic [7:0]                sector;
   logic [7:0]                data;
   logic                      step_dir; // 1 = toward higher tracks
   logic [31:0]               delay;
   logic                      busy;
   logic                      type1;
   logic                      cmd_wr;
   logic                      upd;
   logic [7:0]                status;

   assign busy   = state != fdc_drive_pkg::st_idle;
   assign type1  = fdc_reg_pkg::is_type1(cmd);
   assign cmd_wr = bus.wr_stb && bus.addr == fdc_reg_pkg::reg_status;
   assign op     = fdc_reg_pkg::decode_op(bus.wdata);
   assign upd    = bus.wdata[fdc_reg_pkg::STEP_UPDATE_BIT];

   // crc / record-not-found bits stay zero
   assign status = {motor_on, wr_prot, type1 && spun_up, 2'b00,
                    type1 && (track == 8'd0), type1 ? index_pulse : busy, busy};

   always_comb begin
      case (bus.addr)
         fdc_reg_pkg::reg_status: bus.rdata = status;
         fdc_reg_pkg::reg_track:  bus.rdata = track;
         fdc_reg_pkg::reg_sector: bus.rdata = sector;
         default:                 bus.rdata = data;
      endcase
   end

   assign io.cmd      = cmd;
   assign io.track    = track;
   assign io.sector   = sector;
   assign io.data     = data;
   assign io.state    = state;
   assign io.drv_sel  = drv_sel;
   assign io.drv_side = drv_side;

   always_ff @(posedge clk or posedge motor_start) begin
      if (motor_start) begin
         cmd        <= 8'h00;
         track      <= 8'h00;
         sector     <= 8'h00;
         data       <= 8'h00;
         step_dir   <= 1'b0;
         delay      <= 32'd0;
         state      <= fdc_drive_pkg::st_idle;
         irq        <= 1'b0;
         motor_kick <= 1'b0;
      end else begin
         motor_kick <= 1'b0;

         case (state)
            fdc_drive_pkg::st_int_wait: begin
               if (delay != 32'd0)
                  delay <= delay - 32'd1;
               else
                  state <= fdc_drive_pkg::st_irq;
            end
            fdc_drive_pkg::st_io_wait:
               if (io.dma_done)
                  state <= fdc_drive_pkg::st_irq;   // transfer done
            fdc_drive_pkg::st_irq: begin
               irq   <= 1'b1;
               state <= fdc_drive_pkg::st_idle;
            end
            default: ;                              // idle holds
         endcase

         if (bus.rd_stb && bus.addr == fdc_reg_pkg::reg_status)
            irq <= 1'b0;                            // status read acks irq

         if (bus.wr_stb) begin
            case (bus.addr)
               fdc_reg_pkg::reg_track:  track  <= bus.wdata;
               fdc_reg_pkg::reg_sector: sector <= bus.wdata;
               fdc_reg_pkg::reg_data:   data   <= bus.wdata;
               default: ;                           // command below
            endcase
         end

         if (cmd_wr) begin
            cmd        <= bus.wdata;
            irq        <= 1'b0;
            state      <= fdc_drive_pkg::st_int_wait;
            delay      <= 32'd0;
            // type I and II spin the motor
            motor_kick <= fdc_reg_pkg::is_type1(bus.wdata) ||
                          fdc_reg_pkg::is_type2(bus.wdata);
            case (op)
               fdc_reg_pkg::op_restore: begin
                  track <= 8'd0;
                  delay <= RESTORE_DELAY;
               end
               fdc_reg_pkg::op_seek: begin
                  track <= data;                    // target track in data reg
                  delay <= SEEK_DELAY;
               end
               fdc_reg_pkg::op_step: begin
                  delay <= STEP_DELAY;
                  if (upd)
                     track <= step_dir ? track + 8'd1 : track - 8'd1;
               end
               fdc_reg_pkg::op_step_in: begin
                  delay    <= STEP_DELAY;
                  step_dir <= 1'b1;
                  if (upd)
                     track <= track + 8'd1;
               end
               fdc_reg_pkg::op_step_out: begin
                  delay    <= STEP_DELAY;
                  step_dir <= 1'b0;
                  if (upd)
                     track <= track - 8'd1;
               end
               fdc_reg_pkg::op_read_sector,
               fdc_reg_pkg::op_read_address,
               fdc_reg_pkg::op_read_track:
                  state <= fdc_drive_pkg::st_io_wait;
               fdc_reg_pkg::op_write_sector,
               fdc_reg_pkg::op_write_track:
                  if (!wr_prot)                     // protected: int_wait, delay 0
                     state <= fdc_drive_pkg::st_io_wait;
               default:                             // force interrupt
                  state <= (bus.wdata[3:0] == 4'h0) ? fdc_drive_pkg::st_idle
                                                    : fdc_drive_pkg::st_irq;
            endcase
         end
      end
   end

endmodule

// ==== hw/fdc_drive_model.sv ====
// ======================================================================
// spindle motor run-down, spin-up flag and index pulse
// ======================================================================
`timescale 1ns/1ns

module fdc_drive_model #(
   parameter logic [31:0] MOTOR_RUN    = fdc_drive_pkg::DEF_MOTOR_RUN,
   parameter logic [31:0] MOTOR_SPINUP = fdc_drive_pkg::DEF_MOTOR_SPINUP,
   parameter logic [31:0] INDEX_PERIOD = fdc_drive_pkg::DEF_INDEX_PERIOD,
   parameter logic [31:0] INDEX_WIDTH  = fdc_drive_pkg::DEF_INDEX_WIDTH
) (
   input  logic clk,
   input  logic motor_start,
   input  logic motor_kick,
   output logic motor_on,
   output logic spun_up,
   output logic index_pulse
);

   logic [31:0] motor_cnt;   // cycles until the motor stops
   logic [31:0] rot_cnt;     // position within one rotation

   assign motor_on    = motor_cnt != 32'd0;
   assign spun_up     = motor_on && (motor_cnt <= MOTOR_RUN);  // above = spinning up
   assign index_pulse = motor_on && (rot_cnt < INDEX_WIDTH);

   always_ff @(posedge clk or posedge motor_start) begin
      if (motor_start) begin
         motor_cnt <= 32'd0;
         rot_cnt   <= 32'd0;
      end else begin
         if (motor_kick)
            motor_cnt <= motor_on ? MOTOR_RUN : MOTOR_RUN + MOTOR_SPINUP;
         else if (motor_on)
            motor_cnt <= motor_cnt - 32'd1;

         // rotation restarts at the index hole
         if (!motor_on || rot_cnt == INDEX_PERIOD)
            rot_cnt <= 32'd0;
         else
            rot_cnt <= rot_cnt + 32'd1;
      end
   end

endmodule

// ==== hw/fdc_drive_pkg.sv ====
// ======================================================================
// engine states, status select codes and default drive timing
// ======================================================================
package fdc_drive_pkg;

   typedef enum logic [1:0] {
      st_idle     = 2'd0,
      st_irq      = 2'd1,                // last busy cycle, raises irq
      st_int_wait = 2'd2,                // internal delay running
      st_io_wait  = 2'd3                 // waiting for the io controller
   } fdc_state_e;

   typedef enum logic [2:0] {
      sel_cmd    = 3'd0,
      sel_track  = 3'd1,
      sel_sector = 3'd2,
      sel_data   = 3'd3,
      sel_drive  = 3'd4
   } status_sel_e;

   // clk cycles at 8 MHz
   localparam logic [31:0] DEF_RESTORE_DELAY = 32'd2_000_000;  // 250 ms
   localparam logic [31:0] DEF_SEEK_DELAY    = 32'd200_000;    // 25 ms
   localparam logic [31:0] DEF_STEP_DELAY    = 32'd20_000;     // 2.5 ms
   localparam logic [31:0] DEF_MOTOR_RUN     = 32'd16_000_000; // 2 s run-down
   localparam logic [31:0] DEF_MOTOR_SPINUP  = 32'd8_000_000;  // 1 s extra from cold
   localparam logic [31:0] DEF_INDEX_PERIOD  = 32'd1_600_000;  // 300 rpm
   localparam logic [31:0] DEF_INDEX_WIDTH   = 32'd100_000;    // 1/16 rotation

endpackage

// ==== hw/fdc_io_if.sv ====
// ======================================================================
// register contents and wait state toward the io-controller port
// ======================================================================
`timescale 1ns/1ns

interface fdc_io_if;

   logic [7:0]                cmd;
   logic [7:0]                track;
   logic [7:0]                sector;
   logic [7:0]                data;
   fdc_drive_pkg::fdc_state_e state;
   logic [1:0]                drv_sel;   // reported only
   logic                      drv_side;
   logic                      dma_done;  // one pulse per dma_ack rise

   modport engine (
      output cmd, track, sector, data, state, drv_sel, drv_side,
      input  dma_done
   );

   modport port (
      input  cmd, track, sector, data, state, drv_sel, drv_side,
      output dma_done
   );

endinterface

// ==== hw/fdc_io_port.sv ====
// ======================================================================
// io-controller status snapshot and dma_ack completion event
// ======================================================================
`timescale 1ns/1ns

module fdc_io_port (
   input  logic       clk,
   input  logic       motor_start,
   input  logic       dma_ack,
   input  logic [2:0] status_sel,
   output logic [7:0] status_byte,
   fdc_io_if.port     io
);

   logic dma_ack_q;   // previous ack, for the edge

   always_ff @(posedge clk or posedge motor_start) begin
      if (motor_start) begin
         dma_ack_q   <= 1'b0;
         io.dma_done <= 1'b0;
      end else begin
         dma_ack_q   <= dma_ack;
         io.dma_done <= dma_ack && !dma_ack_q;   // held ack counts once
      end
   end

   always_comb begin
      case (fdc_drive_pkg::status_sel_e'(status_sel))
         fdc_drive_pkg::sel_cmd:    status_byte = io.cmd;
         fdc_drive_pkg::sel_track:  status_byte = io.track;
         fdc_drive_pkg::sel_sector: status_byte = io.sector;
         fdc_drive_pkg::sel_data:   status_byte = io.data;
         fdc_drive_pkg::sel_drive:
            status_byte = {4'b0000, io.drv_sel, io.drv_side,
                           io.state == fdc_drive_pkg::st_io_wait};
         default:                   status_byte = 8'h00;
      endcase
   end

endmodule

// ==== hw/fdc_reg_pkg.sv ====
// ======================================================================
// register map, command opcodes and command class helpers
// ======================================================================
package fdc_reg_pkg;

   localparam int AXI_ADDR_W      = 4;   // byte address, word index in 3:2
   localparam int AXI_DATA_W      = 32;
   localparam int STEP_UPDATE_BIT = 4;   // track update flag of step commands

   // cpu visible registers
   typedef enum logic [1:0] {
      reg_status = 2'd0,                 // status on read, command on write
      reg_track  = 2'd1,
      reg_sector = 2'd2,
      reg_data   = 2'd3
   } reg_addr_e;

   // command bits 7:4, paired codes named by the even one
   typedef enum logic [3:0] {
      op_restore      = 4'h0,
      op_seek         = 4'h1,
      op_step         = 4'h2,
      op_step_in      = 4'h4,
      op_step_out     = 4'h6,
      op_read_sector  = 4'h8,
      op_write_sector = 4'ha,
      op_read_address = 4'hc,
      op_force_int    = 4'hd,
      op_read_track   = 4'he,
      op_write_track  = 4'hf
   } cmd_op_e;

   // fold the odd code of a pair onto its even partner
   function automatic cmd_op_e decode_op(input logic [7:0] cmd);
      logic [3:0] code;
      code = cmd[7:4];
      if (code inside {[4'h2:4'hb]})
         code[0] = 1'b0;
      return cmd_op_e'(code);
   endfunction

   function automatic logic is_type1(input logic [7:0] cmd);
      return !cmd[7];                    // restore .. step-out
   endfunction

   function automatic logic is_type2(input logic [7:0] cmd);
      return cmd[7:6] == 2'b10;          // sector read/write
   endfunction

endpackage

// ==== hw/fdc_top.sv ====
// ======================================================================
// controller top level, AXI4-Lite side, engine, drive model, io port
// ======================================================================
`timescale 1ns/1ns

module fdc_top #(
   parameter logic [31:0] RESTORE_DELAY = fdc_drive_pkg::DEF_RESTORE_DELAY,
   parameter logic [31:0] SEEK_DELAY    = fdc_drive_pkg::DEF_SEEK_DELAY,
   parameter logic [31:0] STEP_DELAY    = fdc_drive_pkg::DEF_STEP_DELAY,
   parameter logic [31:0] MOTOR_RUN     = fdc_drive_pkg::DEF_MOTOR_RUN,
   parameter logic [31:0] MOTOR_SPINUP  = fdc_drive_pkg::DEF_MOTOR_SPINUP,
   parameter logic [31:0] INDEX_PERIOD  = fdc_drive_pkg::DEF_INDEX_PERIOD,
   parameter logic [31:0] INDEX_WIDTH   = fdc_drive_pkg::DEF_INDEX_WIDTH
) (
   input  logic                                 clk,
   input  logic                                 motor_start,
   input  logic                                 awvalid,
   input  logic [fdc_reg_pkg::AXI_ADDR_W-1:0]   awaddr,
   output logic                                 awready,
   input  logic                                 wvalid,
   input  logic [fdc_reg_pkg::AXI_DATA_W-1:0]   wdata,
   input  logic [fdc_reg_pkg::AXI_DATA_W/8-1:0] wstrb,
   output logic                                 wready,
   output logic                                 bvalid,
   output logic [1:0]                           bresp,
   input  logic                                 bready,
   input  logic                                 arvalid,
   input  logic [fdc_reg_pkg::AXI_ADDR_W-1:0]   araddr,
   output logic                                 arready,
   output logic                                 rvalid,
   output logic [fdc_reg_pkg::AXI_DATA_W-1:0]   rdata,
   output logic [1:0]                           rresp,
   input  logic                                 rready,
   input  logic [1:0]                           drv_sel,
   input  logic                                 drv_side,
   input  logic                                 wr_prot,
   input  logic                                 dma_ack,
   input  logic [2:0]                           status_sel,
   output logic [7:0]                           status_byte,
   output logic                                 irq
);

   logic motor_kick;
   logic motor_on;
   logic spun_up;
   logic index_pulse;

   fdc_bus_if bus_if_i ();
   fdc_io_if  io_if_i ();

   fdc_axil_slave axil_i (
      .clk, .motor_start,
      .awvalid, .awaddr, .awready, .wvalid, .wdata, .wstrb, .wready,
      .bvalid, .bresp, .bready,
      .arvalid, .araddr, .arready, .rvalid, .rdata, .rresp, .rready,
      .bus (bus_if_i.slave)
   );

   fdc_cmd_engine #(
      .RESTORE_DELAY (RESTORE_DELAY),
      .SEEK_DELAY    (SEEK_DELAY),
      .STEP_DELAY    (STEP_DELAY)
   ) engine_i (
      .clk, .motor_start, .wr_prot, .drv_sel, .drv_side,
      .motor_on, .spun_up, .index_pulse, .motor_kick, .irq,
      .bus (bus_if_i.engine),
      .io  (io_if_i.engine)
   );

   fdc_drive_model #(
      .MOTOR_RUN    (MOTOR_RUN),
      .MOTOR_SPINUP (MOTOR_SPINUP),
      .INDEX_PERIOD (INDEX_PERIOD),
      .INDEX_WIDTH  (INDEX_WIDTH)
   ) drive_i (
      .clk, .motor_start, .motor_kick, .motor_on, .spun_up, .index_pulse
   );

   fdc_io_port io_port_i (
      .clk, .motor_start, .dma_ack, .status_sel, .status_byte,
      .io (io_if_i.port)
   );

endmodule

// ==== tests/fdc_asserts.sv ====
// ======================================================================
// AXI response hold, irq origin and io_wait checks bound into fdc_top
// ======================================================================
`timescale 1ns/1ns

module fdc_asserts (
   input logic                      clk,
   input logic                      motor_start,
   input logic                      bvalid,
   input logic                      bready,
   input logic                      rvalid,
   input logic                      rready,
   input logic                      irq,
   input logic [2:0]                status_sel,
   input logic [7:0]                status_byte,
   input fdc_drive_pkg::fdc_state_e state
);

   int fail_cnt = 0;   // read by the testbench summary

   // responses stay up until taken
   bvalid_hold: assert property (@(posedge clk) disable iff (motor_start)
      bvalid && !bready |=> bvalid)
   else begin
      fail_cnt++;
      $error("bvalid dropped before bready");
   end

   rvalid_hold: assert property (@(posedge clk) disable iff (motor_start)
      rvalid && !rready |=> rvalid)
   else begin
      fail_cnt++;
      $error("rvalid dropped before rready");
   end

   // irq only out of the irq state
   irq_origin: assert property (@(posedge clk) disable iff (motor_start)
      $rose(irq) |-> $past(state) == fdc_drive_pkg::st_irq)
   else begin
      fail_cnt++;
      $error("irq rose outside the irq state");
   end

   // reported io_wait means busy
   io_wait_busy: assert property (@(posedge clk) disable iff (motor_start)
      (status_sel == fdc_drive_pkg::sel_drive && status_byte[0])
         |-> state != fdc_drive_pkg::st_idle)
   else begin
      fail_cnt++;
      $error("io_wait flag set while idle");
   end

endmodule

bind fdc_top fdc_asserts fdc_asserts_i (
   .clk, .motor_start, .bvalid, .bready, .rvalid, .rready, .irq,
   .status_sel, .status_byte,
   .state (io_if_i.state)
);

// ==== tests/fdc_tb.sv ====
// ======================================================================
// testbench for fdc_top: AXI4-Lite tasks, stimulus, checks, summary
// ======================================================================
`timescale 1ns/1ns

module fdc_tb;

   localparam int WAIT_LIMIT = 1000;   // cycles per handshake or irq wait
   localparam int POLL_LIMIT = 200;    // status reads per poll

   logic        clk = 1'b0;
   logic        motor_start;
   logic        awvalid, wvalid, bready, arvalid, rready;
   logic [3:0]  awaddr, araddr, wstrb;
   logic [31:0] wdata;
   logic        awready, wready, bvalid, arready, rvalid;
   logic [1:0]  bresp, rresp;
   logic [31:0] rdata;
   logic [1:0]  drv_sel;
   logic        drv_side, wr_prot, dma_ack, irq;
   logic [2:0]  status_sel;
   logic [7:0]  status_byte;

   int          checks = 0;
   int          errors = 0;
   int          timeouts = 0;
   logic [7:0]  st, val, trk;

   fdc_top #(
      .RESTORE_DELAY (32'd40),
      .SEEK_DELAY    (32'd20),
      .STEP_DELAY    (32'd10),
      .MOTOR_RUN     (32'd200),
      .MOTOR_SPINUP  (32'd100),
      .INDEX_PERIOD  (32'd30),
      .INDEX_WIDTH   (32'd4)
   ) fdc_top_i (.*);

   always #10 clk = ~clk;   // 20 ns period

   task automatic check_byte(input string name, input logic [7:0] got,
                             input logic [7:0] exp);
      checks++;
      assert (got === exp)
      else begin
         errors++;
         $display("[ERROR] %0t %s expected %02h got %02h", $time, name, exp, got);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      assert (got === exp)
      else begin
         errors++;
         $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, got);
      end
   endtask

   // called at a rising edge, returns at a rising edge
   task automatic axi_write(input logic [1:0] idx, input logic [7:0] b,
                            input logic [3:0] strb);
      int n;
      awvalid <= 1'b1;
      awaddr  <= {idx, 2'b00};
      wvalid  <= 1'b1;
      wdata   <= {24'h0, b};
      wstrb   <= strb;
      n = 0;
      @(negedge clk);
      while (!(awready && wready) && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!(awready && wready)) begin
         timeouts++;
         $display("timeout: write address and data never accepted");
      end
      @(posedge clk);                   // handshake edge
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      n = 0;
      @(negedge clk);
      while (!bvalid && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!bvalid) begin
         timeouts++;
         $display("timeout: write response never came");
      end
      check_byte("bresp", {6'd0, bresp}, 8'h00);
      @(posedge clk);
      bready <= 1'b1;                   // one cycle of back-pressure first
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic axi_read(input logic [1:0] idx, output logic [7:0] b);
      int n;
      arvalid <= 1'b1;
      araddr  <= {idx, 2'b00};
      n = 0;
      @(negedge clk);
      while (!arready && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!arready) begin
         timeouts++;
         $display("timeout: read address never accepted");
      end
      @(posedge clk);
      arvalid <= 1'b0;
      n = 0;
      @(negedge clk);
      while (!rvalid && n < WAIT_LIMIT) begin
         @(negedge clk);
         n++;
      end
      if (!rvalid) begin
         timeouts++;
         $display("timeout: read data never came");
      end
      b = rdata[7:0];
      check_byte("rresp", {6'd0, rresp}, 8'h00);
      @(posedge clk);
      rready <= 1'b1;                   // held back one cycle
      @(posedge clk);
      rready <= 1'b0;
   endtask

   // no_io: io_wait must stay low meanwhile, needs the drive select
   task automatic wait_irq(input logic no_io);
      int n;
      n = 0;
      @(negedge clk);
      while (!irq && n < WAIT_LIMIT) begin
         if (no_io)
            check_bit("status_byte[0]", status_byte[0], 1'b0);
         @(negedge clk);
         n++;
      end
      if (!irq) begin
         timeouts++;
         $display("timeout: irq never rose");
      end
      @(posedge clk);
   endtask

   task automatic wait_status(input logic [2:0] idx, input logic v, input string what,
                              output logic [7:0] s);
      int n;
      n = 0;
      axi_read(2'd0, s);
      while (s[idx] !== v && n < POLL_LIMIT) begin
         axi_read(2'd0, s);
         n++;
      end
      if (s[idx] !== v) begin
         timeouts++;
         $display("timeout: status never showed %s", what);
      end
   endtask

   // busy until irq, then track and status checked, irq acked
   task automatic run_type1(input logic [7:0] cmd, input logic [7:0] exp_trk);
      logic [7:0] s;
      axi_write(2'd0, cmd, 4'hf);
      axi_read(2'd0, s);
      check_bit("status busy", s[0], 1'b1);
      wait_irq(1'b0);
      axi_read(2'd1, s);
      check_byte("track", s, exp_trk);
      axi_read(2'd0, s);
      check_bit("status busy", s[0], 1'b0);
      check_bit("status track0", s[2], exp_trk == 8'd0);
      @(negedge clk);
      check_bit("irq", irq, 1'b0);      // cleared by the status read
      @(posedge clk);
   endtask

   task automatic check_sel(input logic [2:0] sel, input string name,
                            input logic [7:0] exp);
      status_sel <= sel;
      @(negedge clk);
      check_byte(name, status_byte, exp);
      @(posedge clk);
   endtask

   initial begin
      motor_start = 1'b1;
      awvalid     = 1'b0;
      awaddr      = 4'h0;
      wvalid      = 1'b0;
      wdata       = 32'h0;
      wstrb       = 4'h0;
      bready      = 1'b0;
      arvalid     = 1'b0;
      araddr      = 4'h0;
      rready      = 1'b0;
      drv_sel     = 2'b10;
      drv_side    = 1'b1;
      wr_prot     = 1'b0;
      dma_ack     = 1'b0;
      status_sel  = 3'd0;
      void'($urandom(90));
      repeat (3) @(posedge clk);
      motor_start <= 1'b0;
      @(posedge clk);

      // register readback, random bytes
      val = 8'($urandom);
      axi_write(2'd1, val, 4'hf);
      axi_write(2'd1, ~val, 4'he);      // byte 0 masked, no change
      axi_read(2'd1, st);
      check_byte("track", st, val);
      check_sel(3'd1, "status_byte track", val);
      val = 8'($urandom);
      axi_write(2'd2, val, 4'hf);
      axi_read(2'd2, st);
      check_byte("sector", st, val);
      check_sel(3'd2, "status_byte sector", val);
      val = 8'($urandom);
      axi_write(2'd3, val, 4'hf);
      axi_read(2'd3, st);
      check_byte("data", st, val);
      check_sel(3'd4, "status_byte drive", 8'h0a);   // sel 10, side 1, idle

      // type I, expected track from the command rules
      trk = 8'd0;
      run_type1(8'h00, trk);            // restore
      trk = 8'($urandom);
      axi_write(2'd3, trk, 4'hf);
      run_type1(8'h10, trk);            // seek to data
      trk = trk + 8'd1;
      run_type1(8'h50, trk);            // step-in, update
      trk = trk - 8'd1;
      run_type1(8'h70, trk);            // step-out, update
      trk = trk - 8'd1;
      run_type1(8'h30, trk);            // step keeps outward
      run_type1(8'h40, trk);            // step-in, no update
      trk = trk + 8'd1;
      run_type1(8'h30, trk);            // step now inward

      // read sector waits for the io controller
      axi_write(2'd0, 8'h80, 4'hf);
      @(negedge clk);
      check_bit("status_byte io_wait", status_byte[0], 1'b1);
      @(posedge clk);
      axi_read(2'd0, st);
      check_byte("status busy bits", {6'd0, st[1:0]}, 8'h03);
      dma_ack <= 1'b1;
      wait_irq(1'b0);
      dma_ack <= 1'b0;
      @(negedge clk);
      check_bit("status_byte io_wait", status_byte[0], 1'b0);
      @(posedge clk);
      axi_read(2'd0, st);
      check_bit("status busy", st[0], 1'b0);

      // write sector on a protected disk
      wr_prot <= 1'b1;
      axi_write(2'd0, 8'ha0, 4'hf);
      wait_irq(1'b1);
      axi_read(2'd0, st);
      check_bit("status wr_prot", st[6], 1'b1);
      check_bit("status busy", st[0], 1'b0);
      wr_prot <= 1'b0;

      // force interrupt, silent then with condition bits
      axi_write(2'd0, 8'h00, 4'hf);
      axi_write(2'd0, 8'hd0, 4'hf);
      @(negedge clk);
      check_bit("irq", irq, 1'b0);
      @(posedge clk);
      axi_read(2'd0, st);
      check_bit("status busy", st[0], 1'b0);
      axi_write(2'd0, 8'hd8, 4'hf);
      wait_irq(1'b0);
      axi_read(2'd0, st);

      // motor from cold, spin-up, index, run-down
      wait_status(3'd7, 1'b0, "motor off", st);
      axi_write(2'd0, 8'h00, 4'hf);
      axi_read(2'd0, st);
      check_bit("status motor_on", st[7], 1'b1);
      check_bit("status spun_up", st[5], 1'b0);
      wait_status(3'd0, 1'b0, "restore done", st);
      wait_status(3'd5, 1'b1, "spin-up", st);
      check_bit("status motor_on", st[7], 1'b1);
      wait_status(3'd1, 1'b1, "index pulse", st);
      wait_status(3'd1, 1'b0, "index pulse end", st);
      check_bit("status motor_on", st[7], 1'b1);
      wait_status(3'd7, 1'b0, "motor stop", st);

      $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
               checks, errors, timeouts, fdc_top_i.fdc_asserts_i.fail_cnt);
      if (errors == 0 && timeouts == 0 && fdc_top_i.fdc_asserts_i.fail_cnt == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

// ==== vlog.f ====
hw/fdc_reg_pkg.sv
hw/fdc_drive_pkg.sv
hw/fdc_bus_if.sv
hw/fdc_io_if.sv
hw/fdc_axil_slave.sv
hw/fdc_cmd_engine.sv
hw/fdc_drive_model.sv
hw/fdc_io_port.sv
hw/fdc_top.sv
tests/fdc_asserts.sv
tests/fdc_tb.sv
